// File: Makefile
# Verilator build for the fetch front end

VERILATOR ?= verilator
FILELIST  ?= list.f
TB_TOP    ?= fetch_front_end_tb
RTL_TOP   ?= fetch_front_end
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
LINTFLAGS ?= -Wall
PASS_MSG  ?= Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
	  --Mdir $(OBJ_DIR) -o $(TB_TOP)
	./$(OBJ_DIR)/$(TB_TOP) | awk -v msg="$(PASS_MSG)" \
	  '{ print } $$0 == msg { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
rtl/fetch_pkg.sv
rtl/icache_mem.sv
rtl/icache_miss_fsm.sv
rtl/fetch_pc.sv
rtl/fetch_buffer.sv
rtl/fetch_front_end.sv
sim/fetch_front_end_tb.sv

// File: rtl/fetch_buffer.sv
`default_nettype none

module fetch_buffer import fetch_pkg::*; #(
  parameter int FB_DEPTH = 8
) (
  input  logic         clock,
  input  logic         rst,
  input  logic         push,
  input  addr_t        push_pc,
  input  line_t        push_line,
  input  logic         flush,
  input  logic         take,
  output logic         full,
  output logic         out_valid,
  output fetch_block_t out_block
);

  localparam int PTR_W = $clog2(FB_DEPTH);

  fetch_block_t entries [FB_DEPTH];

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W:0]   count;

  fetch_block_t push_block;
  logic         pop;

  // Word offset of pc decides which lanes are live
  always_comb begin
    push_block.pc = block_align(push_pc);
    for (int i = 0; i < NUM_SUPER; i++) begin
      push_block.inst[i]       = push_line[i*32 +: 32];
      push_block.lane_valid[i] = (i >= int'(push_pc[OFFSET_W-1:2]));
    end
  end

  assign out_valid = (count != '0);
  assign full      = (count == (PTR_W+1)'(FB_DEPTH));
  assign pop       = take && out_valid;  // take ignored when empty

  assign out_block = entries[head];

  always_ff @(posedge clock) begin
    if (rst || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clock) begin
    if (push && !flush) begin
      entries[tail] <= push_block;
    end
  end

  // Upstream must hold off while full
  a_no_push_when_full: assert property (
    @(posedge clock) disable iff (rst)
    push |-> !full
  );

endmodule

`default_nettype wire

// File: rtl/fetch_front_end.sv
`default_nettype none

module fetch_front_end import fetch_pkg::*; #(
  parameter int    FB_DEPTH = 8,
  parameter addr_t RESET_PC = '0
) (
  input  logic         clock,
  input  logic         rst,
  input  mem_tag_t     mem2proc_response,  // Nonzero accepts the command
  input  line_t        mem2proc_data,
  input  mem_tag_t     mem2proc_tag,       // Marks returning data
  input  logic         redirect_en,
  input  addr_t        redirect_pc,
  input  logic         take,
  output bus_cmd_e     proc2mem_command,
  output addr_t        proc2mem_addr,
  output logic         out_valid,
  output fetch_block_t out_block
);

  addr_t pc;
  logic  hit;
  line_t line;
  logic  advance;
  logic  full;
  logic  fill_en;
  addr_t fill_pc;

  fetch_pc #(
    .RESET_PC (RESET_PC)
  ) fetch_pc_0 (
    .clock       (clock),
    .rst         (rst),
    .advance     (advance),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .pc          (pc)
  );

  icache_mem icache_mem_0 (
    .clock   (clock),
    .rst     (rst),
    .rd_pc   (pc),
    .wr_en   (fill_en),
    .wr_pc   (fill_pc),
    .wr_line (mem2proc_data),
    .hit     (hit),
    .rd_line (line)
  );

  icache_miss_fsm miss_fsm_0 (
    .clock             (clock),
    .rst               (rst),
    .pc                (pc),
    .hit               (hit),
    .full              (full),
    .redirect_en       (redirect_en),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .advance           (advance),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .fill_en           (fill_en),
    .fill_pc           (fill_pc)
  );

  fetch_buffer #(
    .FB_DEPTH (FB_DEPTH)
  ) fetch_buffer_0 (
    .clock     (clock),
    .rst       (rst),
    .push      (advance),
    .push_pc   (pc),
    .push_line (line),
    .flush     (redirect_en),
    .take      (take),
    .full      (full),
    .out_valid (out_valid),
    .out_block (out_block)
  );

endmodule

`default_nettype wire

// File: rtl/fetch_pc.sv
`default_nettype none

module fetch_pc import fetch_pkg::*; #(
  parameter addr_t RESET_PC = '0
) (
  input  logic  clock,
  input  logic  rst,
  input  logic  advance,
  input  logic  redirect_en,
  input  addr_t redirect_pc,
  output addr_t pc
);

  addr_t next_pc;

  // Always lands on an aligned block, even after an odd-word redirect
  assign next_pc = block_align(pc) + addr_t'(BLOCK_BYTES);

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (redirect_en) begin
      pc <= redirect_pc;  // Redirect wins over step
    end else if (advance) begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// File: rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Instructions per fetch block
  localparam int NUM_SUPER = 2;

  // Address slicing, 8 bytes per line
  localparam int OFFSET_W = 3;
  localparam int IDX_W    = 5;
  localparam int TAG_W    = 8;

  localparam int IDX_LO      = OFFSET_W;          // Index is pc[7:3]
  localparam int TAG_LO      = OFFSET_W + IDX_W;  // Tag is pc[15:8]
  localparam int NUM_LINES   = 1 << IDX_W;
  localparam int BLOCK_BYTES = 1 << OFFSET_W;

  typedef logic [63:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [63:0] line_t;
  typedef logic [3:0]  mem_tag_t;  // Zero means no transaction

  // Memory command encoding
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  typedef enum logic [1:0] {
    MISS_IDLE,
    MISS_REQUEST,
    MISS_WAIT_DATA
  } miss_state_e;

  // Lane 0 holds the lower word of the line
  typedef struct packed {
    addr_t                 pc;
    inst_t [NUM_SUPER-1:0] inst;
    logic  [NUM_SUPER-1:0] lane_valid;
  } fetch_block_t;

  function automatic addr_t block_align(addr_t a);
    return {a[63:OFFSET_W], {OFFSET_W{1'b0}}};
  endfunction

endpackage

`default_nettype wire

// File: rtl/icache_mem.sv
`default_nettype none

module icache_mem import fetch_pkg::*; (
  input  logic  clock,
  input  logic  rst,
  input  addr_t rd_pc,
  input  logic  wr_en,
  input  addr_t wr_pc,
  input  line_t wr_line,
  output logic  hit,
  output line_t rd_line
);

  logic [NUM_LINES-1:0] valid;
  logic [TAG_W-1:0]     tags  [NUM_LINES];
  line_t                lines [NUM_LINES];

  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [TAG_W-1:0] wr_tag;

  assign rd_idx = rd_pc[IDX_LO +: IDX_W];
  assign rd_tag = rd_pc[TAG_LO +: TAG_W];
  assign wr_idx = wr_pc[IDX_LO +: IDX_W];
  assign wr_tag = wr_pc[TAG_LO +: TAG_W];

  // Valid bits
  always_ff @(posedge clock) begin
    if (rst) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  // Fill write, tag and line together
  always_ff @(posedge clock) begin
    if (wr_en) begin
      tags[wr_idx]  <= wr_tag;
      lines[wr_idx] <= wr_line;
    end
  end

  // Combinational lookup
  assign hit     = valid[rd_idx] && (tags[rd_idx] == rd_tag);
  assign rd_line = lines[rd_idx];

endmodule

`default_nettype wire

// File: rtl/icache_miss_fsm.sv
`default_nettype none

module icache_miss_fsm import fetch_pkg::*; (
  input  logic     clock,
  input  logic     rst,
  input  addr_t    pc,
  input  logic     hit,
  input  logic     full,
  input  logic     redirect_en,
  input  mem_tag_t mem2proc_response,
  input  mem_tag_t mem2proc_tag,
  output logic     advance,
  output bus_cmd_e proc2mem_command,
  output addr_t    proc2mem_addr,
  output logic     fill_en,
  output addr_t    fill_pc
);

  miss_state_e state;
  miss_state_e state_nxt;
  addr_t       miss_pc;   // Block address of the missing line
  mem_tag_t    pend_tag;

  logic start_fill;
  logic accepted;
  logic tag_match;

  assign advance    = hit && !full && !redirect_en;
  assign start_fill = !hit && !full && !redirect_en;

  assign accepted  = (state == MISS_REQUEST) && (mem2proc_response != '0);
  assign tag_match = (mem2proc_tag == pend_tag);

  always_comb begin
    state_nxt = state;
    case (state)
      MISS_IDLE: begin
        if (start_fill) state_nxt = MISS_REQUEST;
      end
      MISS_REQUEST: begin
        if (accepted) state_nxt = MISS_WAIT_DATA;
      end
      MISS_WAIT_DATA: begin
        // A redirect does not cancel the fill
        if (tag_match) state_nxt = MISS_IDLE;
      end
      default: state_nxt = MISS_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state    <= MISS_IDLE;
      pend_tag <= '0;
    end else begin
      state <= state_nxt;
      if (accepted) begin
        pend_tag <= mem2proc_response;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == MISS_IDLE && start_fill) begin
      miss_pc <= block_align(pc);
    end
  end

  // Load held as a level until accepted
  assign proc2mem_command = (state == MISS_REQUEST) ? BUS_LOAD : BUS_NONE;
  assign proc2mem_addr    = (state == MISS_REQUEST) ? miss_pc : '0;

  assign fill_en = (state == MISS_WAIT_DATA) && tag_match;
  assign fill_pc = miss_pc;

  a_pend_tag_nonzero: assert property (
    @(posedge clock) disable iff (rst)
    state == MISS_WAIT_DATA |-> pend_tag != '0
  );

  // One transaction in flight
  a_cmd_drops_after_accept: assert property (
    @(posedge clock) disable iff (rst)
    proc2mem_command == BUS_LOAD && mem2proc_response != '0
      |=> proc2mem_command == BUS_NONE
  );

endmodule

`default_nettype wire

// File: sim/fetch_front_end_tb.sv
`default_nettype none

module fetch_front_end_tb
  import fetch_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    FB_DEPTH     = 8;
  localparam addr_t RESET_PC     = '0;
  localparam string PATTERN_FILE = "sim/fetch_patterns.txt";

  logic         clock;
  logic         rst;
  mem_tag_t     mem2proc_response;
  line_t        mem2proc_data;
  mem_tag_t     mem2proc_tag;
  logic         redirect_en;
  addr_t        redirect_pc;
  logic         take;
  bus_cmd_e     proc2mem_command;
  addr_t        proc2mem_addr;
  logic         out_valid;
  fetch_block_t out_block;

  logic [31:0] image [addr_t];   // Memory words by byte address
  addr_t       rec_target [$];
  int          rec_count [$];
  int          rec_hold [$];
  addr_t       cmd_log [$];      // Address of every load the memory saw
  addr_t       cached [NUM_LINES];  // Lines known to sit in the cache
  logic [31:0] mem_rng;
  logic [31:0] take_rng;
  logic        loaded;
  int          errors;
  int          tests_passed;
  int          tests_failed;

  fetch_front_end #(
    .FB_DEPTH (FB_DEPTH),
    .RESET_PC (RESET_PC)
  ) u_fetch_front_end (
    .clock             (clock),
    .rst               (rst),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .redirect_en       (redirect_en),
    .redirect_pc       (redirect_pc),
    .take              (take),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .out_valid         (out_valid),
    .out_block         (out_block)
  );

  always #10 clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] image_word(input addr_t a);
    if (image.exists(a)) begin
      return image[a];
    end
    return '0;
  endfunction

  function automatic logic [IDX_W-1:0] line_index(input addr_t a);
    return a[7:3];
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #2;
  endtask

  task automatic load_patterns();
    int          fd;
    string       text;
    addr_t       a;
    logic [31:0] d;
    int          c;
    int          h;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the pattern file %s", PATTERN_FILE);
      errors++;
    end else begin
      while ($fgets(text, fd) != 0) begin
        if ($sscanf(text, "W %h %h", a, d) == 2) begin
          image[a] = d;
        end else if ($sscanf(text, "J %h %d %d", a, c, h) == 3) begin
          rec_target.push_back(a);
          rec_count.push_back(c);
          rec_hold.push_back(h);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic report_test(input string name, input int first_err);
    if (errors == first_err) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - first_err);
    end
  endtask

  task automatic check_reset();
    int first_err;
    first_err = errors;
    if (out_valid !== 1'b0) begin
      $display("CHECK FAILED out_valid: got 0x%h, expected 0x0", out_valid);
      errors++;
    end
    if (proc2mem_command !== BUS_NONE) begin
      $display("CHECK FAILED proc2mem_command: got 0x%h, expected 0x%h",
               proc2mem_command, BUS_NONE);
      errors++;
    end
    report_test("reset", first_err);
  endtask

  task automatic run_record(input int r);
    addr_t      exp_pc;
    addr_t      first_pc;
    addr_t      last_pc;
    logic [1:0] exp_lanes;
    logic       all_hit;
    int         first_err;
    int         log_start;
    int         fills;
    first_err = errors;
    first_pc  = rec_target[r] & ~addr_t'(7);
    last_pc   = first_pc + addr_t'(8 * (rec_count[r] - 1));
    exp_pc    = first_pc;
    exp_lanes = rec_target[r][2] ? 2'b10 : 2'b11;  // Odd word leaves lane 0 dead
    all_hit   = 1'b1;
    for (int k = 0; k < rec_count[r]; k++) begin
      if (cached[line_index(first_pc + addr_t'(8 * k))] !== first_pc + addr_t'(8 * k)) begin
        all_hit = 1'b0;
      end
    end
    log_start = cmd_log.size();
    take        = 1'b0;
    redirect_en = 1'b1;
    redirect_pc = rec_target[r];
    next_cycle();
    redirect_en = 1'b0;
    repeat (rec_hold[r]) next_cycle();  // Let the buffer fill up
    for (int k = 0; k < rec_count[r]; k++) begin
      take_rng = xorshift32(take_rng);
      repeat (take_rng % 3) next_cycle();
      while (out_valid !== 1'b1) next_cycle();
      if (out_block.pc !== exp_pc) begin
        $display("CHECK FAILED out_block.pc: got 0x%h, expected 0x%h", out_block.pc, exp_pc);
        errors++;
      end
      if (out_block.inst[0] !== image_word(exp_pc)) begin
        $display("CHECK FAILED out_block.inst[0]: got 0x%h, expected 0x%h",
                 out_block.inst[0], image_word(exp_pc));
        errors++;
      end
      if (out_block.inst[1] !== image_word(exp_pc + 64'd4)) begin
        $display("CHECK FAILED out_block.inst[1]: got 0x%h, expected 0x%h",
                 out_block.inst[1], image_word(exp_pc + 64'd4));
        errors++;
      end
      if (out_block.lane_valid !== exp_lanes) begin
        $display("CHECK FAILED out_block.lane_valid: got 0x%h, expected 0x%h",
                 out_block.lane_valid, exp_lanes);
        errors++;
      end
      cached[line_index(exp_pc)] = exp_pc;
      take = 1'b1;
      next_cycle();
      take      = 1'b0;
      exp_pc    = exp_pc + 64'd8;
      exp_lanes = 2'b11;
    end
    fills = 0;
    for (int i = log_start; i < cmd_log.size(); i++) begin
      if (cmd_log[i] >= first_pc && cmd_log[i] <= last_pc) begin
        fills++;
      end
    end
    if (all_hit && fills != 0) begin
      $display("Record %0d loaded %0d lines from memory that were already cached", r, fills);
      errors++;
    end
    // Fetch may have run ahead and replaced these lines
    for (int j = 1; j <= FB_DEPTH + 1; j++) begin
      cached[line_index(last_pc + addr_t'(8 * j))] = '1;
    end
    report_test($sformatf("jump 0x%0h count %0d hold %0d, %0d fills", rec_target[r],
                          rec_count[r], rec_hold[r], fills), first_err);
  endtask

  // Tagged memory with random accept and data delays
  initial begin : memory_model
    mem_tag_t next_tag;
    addr_t    req_addr;
    mem_rng           = 32'd56;
    next_tag          = 4'h1;
    mem2proc_response = '0;
    mem2proc_data     = '0;
    mem2proc_tag      = '0;
    forever begin
      next_cycle();
      mem2proc_response = '0;
      mem2proc_tag      = '0;
      if (rst === 1'b0 && proc2mem_command == BUS_LOAD) begin
        req_addr = proc2mem_addr;
        cmd_log.push_back(req_addr);
        if (req_addr[2:0] !== 3'b000) begin  // Requests name whole blocks
          $display("CHECK FAILED proc2mem_addr: got 0x%h, expected 0x%h",
                   req_addr, req_addr & ~addr_t'(7));
          errors++;
        end
        mem_rng = xorshift32(mem_rng);
        repeat (mem_rng % 4) next_cycle();
        mem2proc_response = next_tag;  // Accepted at the next edge
        next_cycle();
        mem2proc_response = '0;
        mem_rng = xorshift32(mem_rng);
        repeat (mem_rng % 4) next_cycle();
        mem2proc_tag  = next_tag;
        mem2proc_data = {image_word(req_addr + 64'd4), image_word(req_addr)};
        next_tag      = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
      end
    end
  end

  initial begin : watchdog
    longint limit;
    wait (loaded === 1'b1);
    limit = 10;  // Reset and setup
    foreach (rec_count[i]) begin
      limit += longint'(rec_count[i]) * longint'(rec_hold[i] + 40);
    end
    #(limit * 20);
    $display("Timeout after %0d cycles with the tests still running", limit);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    clock        = 1'b0;
    rst          = 1'b1;
    redirect_en  = 1'b0;
    redirect_pc  = '0;
    take         = 1'b0;
    take_rng     = 32'd56;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    loaded       = 1'b0;
    foreach (cached[i]) begin
      cached[i] = '1;
    end
    load_patterns();
    loaded = 1'b1;
    repeat (2) @(posedge clock);
    #2;
    rst = 1'b0;
    check_reset();
    foreach (rec_target[r]) begin
      run_record(r);
    end
    $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/fetch_patterns.txt
# W addr data          memory word, hex byte address and hex 32-bit word
# J target count hold  redirect to hex target, hold take low, then take count blocks
W 0000 00000013
W 0004 00100093
W 0008 00200113
W 000c 00300193
W 0014 00500293
W 0020 00800413
W 0038 00e00713
W 004c 01300993
W 0100 40000013
W 0104 40100093
W 0108 40200113
W 0110 40400213
W 011c 40700393
J 0000 20 0
J 0010 6 0
J 0024 8 3
J 0040 12 20
J 0100 4 0
J 0000 4 0
J 0104 5 2
J 0000 5 1
